// ==== design/alu_ops_pkg.sv ====
// ALU operation codes, result select codes and shift kinds
package alu_ops_pkg;

    // Operation codes as issued to the execute block, 10 to 15 are illegal
    typedef enum logic [3:0] {
        OP_AND  = 4'd0,
        OP_OR   = 4'd1,
        OP_ADD  = 4'd2,
        OP_SRL  = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SUB  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9
    } alu_op_t;

    typedef enum logic [2:0] {
        SEL_ADD,   // Adder output, add or subtract
        SEL_AND,
        SEL_OR,
        SEL_XOR,
        SEL_SLT,
        SEL_SLTU,
        SEL_SHIFT,
        SEL_NONE   // Illegal code
    } alu_sel_t;

    typedef enum logic [1:0] {
        SH_SLL,
        SH_SRL,
        SH_SRA
    } shift_kind_t;

endpackage

// ==== design/exec_pkg.sv ====
// Execute pipeline definitions shared by the stages and the verification code
package exec_pkg;

    // Destination register index, passed through untouched
    typedef logic [4:0] tag_t;

    // Cycles from issue_valid to result_valid
    localparam int EXEC_LATENCY = 2;

endpackage

// ==== design/alu_operand_stage.sv ====
// ALU operand stage, registers the issued operation and decodes it into ALU controls
`timescale 1ns/1ps

module alu_operand_stage
    import alu_ops_pkg::*;
    import exec_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  tag_t            tag,
    output logic            dec_valid,
    output alu_sel_t        dec_sel,
    output logic            dec_sub,
    output shift_kind_t     dec_shift,
    output logic [XLEN-1:0] dec_a,
    output logic [XLEN-1:0] dec_b,
    output tag_t            dec_tag
);

    alu_sel_t    sel;
    logic        sub;
    shift_kind_t shift;

    always_comb begin
        sel   = SEL_NONE;
        sub   = 1'b0;
        shift = SH_SLL;
        case (op)
            OP_AND:  sel = SEL_AND;
            OP_OR:   sel = SEL_OR;
            OP_XOR:  sel = SEL_XOR;
            OP_ADD:  sel = SEL_ADD;
            OP_SUB: begin
                sel = SEL_ADD;
                sub = 1'b1;
            end
            // Compares run through the subtractor
            OP_SLT: begin
                sel = SEL_SLT;
                sub = 1'b1;
            end
            OP_SLTU: begin
                sel = SEL_SLTU;
                sub = 1'b1;
            end
            OP_SLL: begin
                sel   = SEL_SHIFT;
                shift = SH_SLL;
            end
            OP_SRL: begin
                sel   = SEL_SHIFT;
                shift = SH_SRL;
            end
            OP_SRA: begin
                sel   = SEL_SHIFT;
                shift = SH_SRA;
            end
            default: sel = SEL_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            dec_sel   <= sel;
            dec_sub   <= sub;
            dec_shift <= shift;
            dec_a     <= a;
            dec_b     <= b;
            dec_tag   <= tag;
        end
    end

endmodule

// ==== design/alu_shifter.sv ====
// Logarithmic barrel shifter for SLL, SRL and SRA
`timescale 1ns/1ps

module alu_shifter
    import alu_ops_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic [XLEN-1:0] value,
    input  logic [XLEN-1:0] amount,
    input  shift_kind_t     kind,
    output logic [XLEN-1:0] shifted
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  amt;
    logic            rev;
    logic            fill;
    logic [XLEN-1:0] src;
    logic [XLEN-1:0] stage;

    assign amt  = amount[SHW-1:0];  // Upper amount bits ignored
    assign rev  = (kind == SH_SLL);
    assign fill = (kind == SH_SRA) ? value[XLEN-1] : 1'b0;

    // Left shift reuses the right shift network on a bit-reversed value
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            src[i] = rev ? value[XLEN-1-i] : value[i];
        end
    end

    always_comb begin
        logic [XLEN-1:0] fill_mask;
        stage = src;
        for (int s = 0; s < SHW; s++) begin
            fill_mask = {XLEN{fill}} & ~({XLEN{1'b1}} >> (1 << s));
            if (amt[s]) begin
                stage = (stage >> (1 << s)) | fill_mask;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            shifted[i] = rev ? stage[XLEN-1-i] : stage[i];
        end
    end

endmodule

// ==== design/alu.sv ====
// Combinational ALU with one shared adder, logic ops, shifter and flag generation
`timescale 1ns/1ps

module alu
    import alu_ops_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  alu_sel_t        sel,
    input  logic            sub,
    input  shift_kind_t     shift_kind,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            z_flag,
    output logic            n_flag,
    output logic            v_flag,
    output logic            c_flag
);

    logic [XLEN-1:0] b_eff;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] shifted;
    logic            carry;
    logic            ovf;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            arith;

    // Subtract is a + ~b + 1
    assign b_eff = sub ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, sub};

    // Same operand signs but result sign differs
    assign ovf = (a[XLEN-1] == b_eff[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);

    assign lt_signed   = sum[XLEN-1] ^ ovf;
    assign lt_unsigned = ~carry;  // Borrow out

    alu_shifter #(
        .XLEN(XLEN)
    ) i_shifter (
        .value  (a),
        .amount (b),
        .kind   (shift_kind),
        .shifted(shifted)
    );

    always_comb begin
        case (sel)
            SEL_ADD:   result = sum;
            SEL_AND:   result = a & b;
            SEL_OR:    result = a | b;
            SEL_XOR:   result = a ^ b;
            SEL_SLT:   result = {{(XLEN-1){1'b0}}, lt_signed};
            SEL_SLTU:  result = {{(XLEN-1){1'b0}}, lt_unsigned};
            SEL_SHIFT: result = shifted;
            default:   result = '0;
        endcase
    end

    // V and C only meaningful for add and subtract
    assign arith  = (sel == SEL_ADD);
    assign z_flag = (result == '0);
    assign n_flag = result[XLEN-1];
    assign v_flag = arith & ovf;
    assign c_flag = arith & carry;

endmodule

// ==== design/alu_exec_stage.sv ====
// ALU execute stage, runs the ALU and registers result, flags and tag
`timescale 1ns/1ps

module alu_exec_stage
    import alu_ops_pkg::*;
    import exec_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dec_valid,
    input  alu_sel_t        dec_sel,
    input  logic            dec_sub,
    input  shift_kind_t     dec_shift,
    input  logic [XLEN-1:0] dec_a,
    input  logic [XLEN-1:0] dec_b,
    input  tag_t            dec_tag,
    output logic            result_valid,
    output logic [XLEN-1:0] result,
    output logic            z_flag,
    output logic            n_flag,
    output logic            v_flag,
    output logic            c_flag,
    output tag_t            result_tag
);

    logic [XLEN-1:0] alu_result;
    logic            alu_z;
    logic            alu_n;
    logic            alu_v;
    logic            alu_c;

    alu #(
        .XLEN(XLEN)
    ) i_alu (
        .sel       (dec_sel),
        .sub       (dec_sub),
        .shift_kind(dec_shift),
        .a         (dec_a),
        .b         (dec_b),
        .result    (alu_result),
        .z_flag    (alu_z),
        .n_flag    (alu_n),
        .v_flag    (alu_v),
        .c_flag    (alu_c)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            result     <= alu_result;
            z_flag     <= alu_z;
            n_flag     <= alu_n;
            v_flag     <= alu_v;
            c_flag     <= alu_c;
            result_tag <= dec_tag;
        end
    end

endmodule

// ==== design/alu_top.sv ====
// Two-stage pipelined ALU execute block, operand decode followed by execute
`timescale 1ns/1ps

module alu_top
    import alu_ops_pkg::*;
    import exec_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  tag_t            tag,
    output logic            result_valid,
    output logic [XLEN-1:0] result,
    output logic            z_flag,
    output logic            n_flag,
    output logic            v_flag,
    output logic            c_flag,
    output tag_t            result_tag
);

    logic            dec_valid;
    alu_sel_t        dec_sel;
    logic            dec_sub;
    shift_kind_t     dec_shift;
    logic [XLEN-1:0] dec_a;
    logic [XLEN-1:0] dec_b;
    tag_t            dec_tag;

    alu_operand_stage #(
        .XLEN(XLEN)
    ) i_operand_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_valid(issue_valid),
        .op         (op),
        .a          (a),
        .b          (b),
        .tag        (tag),
        .dec_valid  (dec_valid),
        .dec_sel    (dec_sel),
        .dec_sub    (dec_sub),
        .dec_shift  (dec_shift),
        .dec_a      (dec_a),
        .dec_b      (dec_b),
        .dec_tag    (dec_tag)
    );

    alu_exec_stage #(
        .XLEN(XLEN)
    ) i_exec_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_sel     (dec_sel),
        .dec_sub     (dec_sub),
        .dec_shift   (dec_shift),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_tag     (dec_tag),
        .result_valid(result_valid),
        .result      (result),
        .z_flag      (z_flag),
        .n_flag      (n_flag),
        .v_flag      (v_flag),
        .c_flag      (c_flag),
        .result_tag  (result_tag)
    );

endmodule

// ==== sim/alu_top_props.sv ====
// Bound checks on the ALU pipeline covering reset state, fixed latency and zero flag
`timescale 1ns/1ps

module alu_top_props
    import exec_pkg::*;
#(
    parameter int XLEN = 64
) (
    input logic            clk,
    input logic            rst_n,
    input logic            issue_valid,
    input logic            result_valid,
    input logic [XLEN-1:0] result,
    input logic            z_flag
);

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !result_valid ##1 !result_valid)
        else $error("result_valid high during or right after reset");

    // Every issue comes out, and nothing comes out without an issue
    a_issue_to_result: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> ##EXEC_LATENCY result_valid)
        else $error("issue did not produce result_valid after the fixed latency");

    a_result_from_issue: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(issue_valid, EXEC_LATENCY))
        else $error("result_valid without a matching issue");

    a_zero_flag: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (z_flag == (result == '0)))
        else $error("z_flag disagrees with the result value");

endmodule

bind alu_top alu_top_props #(.XLEN(XLEN)) i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .result_valid(result_valid),
    .result      (result),
    .z_flag      (z_flag)
);

// ==== sim/alu_top_tb.sv ====
// Table-driven testbench for the two-stage ALU pipeline
`timescale 1ns/1ps

module alu_top_tb
    import alu_ops_pkg::*;
    import exec_pkg::*;
;

    localparam int XLEN = 64;

    typedef struct {
        logic [3:0]      op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        tag_t            tag;
        logic [XLEN-1:0] res;
        logic [3:0]      zncv;   // Expected z, n, v, c
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            issue_valid;
    alu_op_t         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    tag_t            tag;
    logic            result_valid;
    logic [XLEN-1:0] result;
    logic            z_flag;
    logic            n_flag;
    logic            v_flag;
    logic            c_flag;
    tag_t            result_tag;

    row_t        rows[$];
    int          pend_idx[$];
    int          pend_cycle[$];
    int          errors = 0;
    int          cycles = 0;
    int          limit  = 0;
    logic [31:0] rng    = 32'h6389_82e7;

    alu_top #(
        .XLEN(XLEN)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .op          (op),
        .a           (a),
        .b           (b),
        .tag         (tag),
        .result_valid(result_valid),
        .result      (result),
        .z_flag      (z_flag),
        .n_flag      (n_flag),
        .v_flag      (v_flag),
        .c_flag      (c_flag),
        .result_tag  (result_tag)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input logic [3:0] r_op, input logic [XLEN-1:0] r_a,
                           input logic [XLEN-1:0] r_b, input logic [XLEN-1:0] r_res,
                           input logic [3:0] r_zncv);
        row_t r;
        r.op   = r_op;
        r.a    = r_a;
        r.b    = r_b;
        r.tag  = 5'(rows.size());
        r.res  = r_res;
        r.zncv = r_zncv;
        rows.push_back(r);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run;
        $display("Run ended with %0d error(s)", errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    task automatic fill_table;
        add_row(OP_ADD, 64'd1, 64'd2, 64'd3, 4'b0000);
        add_row(OP_ADD, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1, 64'h8000_0000_0000_0000, 4'b0110);
        add_row(OP_ADD, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'd0, 4'b1011);
        add_row(OP_ADD, 64'hFFFF_FFFF_FFFF_FFFF, 64'd2, 64'd1, 4'b0001);  // Unsigned wrap
        add_row(OP_SUB, 64'd5, 64'd5, 64'd0, 4'b1001);
        add_row(OP_SUB, 64'd10, 64'd3, 64'd7, 4'b0001);
        add_row(OP_SUB, 64'd3, 64'd10, 64'hFFFF_FFFF_FFFF_FFF9, 4'b0100);
        add_row(OP_SUB, 64'h8000_0000_0000_0000, 64'd1, 64'h7FFF_FFFF_FFFF_FFFF, 4'b0011);
        add_row(OP_SUB, 64'h7FFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF,
                64'h8000_0000_0000_0000, 4'b0110);
        add_row(OP_AND, 64'hF0F0_F0F0_F0F0_F0F0, 64'hFF00_FF00_FF00_FF00,
                64'hF000_F000_F000_F000, 4'b0100);
        add_row(OP_AND, 64'h5555_5555_5555_5555, 64'hAAAA_AAAA_AAAA_AAAA, 64'd0, 4'b1000);
        add_row(OP_OR, 64'h0000_0000_0000_00F0, 64'h0F, 64'hFF, 4'b0000);
        add_row(OP_XOR, 64'h8000_0000_0000_0001, 64'd1, 64'h8000_0000_0000_0000, 4'b0100);
        add_row(OP_XOR, 64'h1234_5678_9ABC_DEF0, 64'h1234_5678_9ABC_DEF0, 64'd0, 4'b1000);
        // Negative against positive for both compares
        add_row(OP_SLT, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'd1, 4'b0000);
        add_row(OP_SLT, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0, 4'b1000);
        add_row(OP_SLTU, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'd0, 4'b1000);
        add_row(OP_SLTU, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 4'b0000);
        add_row(OP_SLL, 64'd1, 64'd0, 64'd1, 4'b0000);
        add_row(OP_SLL, 64'd1, 64'd1, 64'd2, 4'b0000);
        add_row(OP_SLL, 64'd1, 64'd63, 64'h8000_0000_0000_0000, 4'b0100);
        add_row(OP_SLL, 64'd1, 64'h41, 64'd2, 4'b0000);  // Only low 6 bits count
        add_row(OP_SRL, 64'h8000_0000_0000_0000, 64'd1, 64'h4000_0000_0000_0000, 4'b0000);
        add_row(OP_SRL, 64'h8000_0000_0000_0000, 64'd63, 64'd1, 4'b0000);
        add_row(OP_SRL, 64'h1234_5678_9ABC_DEF0, 64'd0, 64'h1234_5678_9ABC_DEF0, 4'b0000);
        add_row(OP_SRL, 64'hFF00_0000_0000_0000, 64'hC8, 64'h00FF_0000_0000_0000, 4'b0000);
        add_row(OP_SRA, 64'h8000_0000_0000_0000, 64'd1, 64'hC000_0000_0000_0000, 4'b0100);
        add_row(OP_SRA, 64'h8000_0000_0000_0000, 64'd63, 64'hFFFF_FFFF_FFFF_FFFF, 4'b0100);
        add_row(OP_SRA, 64'hF000_0000_0000_0000, 64'h104, 64'hFF00_0000_0000_0000, 4'b0100);
        add_row(OP_SRA, 64'h4000_0000_0000_0000, 64'd62, 64'd1, 4'b0000);
        add_row(OP_SRA, 64'h8000_0000_0000_0001, 64'd0, 64'h8000_0000_0000_0001, 4'b0100);
        add_row(4'd10, 64'd5, 64'd3, 64'd0, 4'b1000);
        add_row(4'd15, 64'hFFFF_FFFF_FFFF_FFFF, 64'd7, 64'd0, 4'b1000);
    endtask

    // Outputs are stable by the falling edge
    always @(negedge clk) begin
        int idx;
        int ic;
        if (rst_n && result_valid) begin
            if (pend_idx.size() == 0) begin
                errors++;
                $display("result_valid was high with no operation outstanding");
            end else begin
                idx = pend_idx.pop_front();
                ic  = pend_cycle.pop_front();
                check("latency", 64'(cycles - ic), 64'(EXEC_LATENCY));
                check("result", result, rows[idx].res);
                check("z_flag", 64'(z_flag), 64'(rows[idx].zncv[3]));
                check("n_flag", 64'(n_flag), 64'(rows[idx].zncv[2]));
                check("v_flag", 64'(v_flag), 64'(rows[idx].zncv[1]));
                check("c_flag", 64'(c_flag), 64'(rows[idx].zncv[0]));
                check("result_tag", 64'(result_tag), 64'(rows[idx].tag));
            end
        end
    end

    initial begin
        @(posedge clk);
        while (cycles < limit) @(posedge clk);
        errors++;
        $display("Timeout after %0d cycles with %0d result(s) outstanding",
                 cycles, pend_idx.size());
        finish_run();
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        op          = OP_AND;
        a           = '0;
        b           = '0;
        tag         = '0;
        fill_table();
        limit = 16 + 2 * rows.size() + 20;

        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) @(posedge clk);  // Quiet window before the first issue

        for (int i = 0; i < rows.size(); i++) begin
            rng = xorshift32(rng);
            if (rng[0]) begin
                @(posedge clk);
                #1 issue_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            issue_valid = 1'b1;
            op          = alu_op_t'(rows[i].op);
            a           = rows[i].a;
            b           = rows[i].b;
            tag         = rows[i].tag;
            pend_idx.push_back(i);
            pend_cycle.push_back(cycles);
        end
        @(posedge clk);
        #1 issue_valid = 1'b0;

        while (pend_idx.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        finish_run();
    end

endmodule

// ==== alu_top.f ====
design/alu_ops_pkg.sv
design/exec_pkg.sv
design/alu_operand_stage.sv
design/alu_shifter.sv
design/alu.sv
design/alu_exec_stage.sv
design/alu_top.sv
sim/alu_top_props.sv
sim/alu_top_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = alu_top_tb
FILELIST  = alu_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^TB PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
